// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := riscvIntCore_tb
FILELIST := riscvIntCore.f
BUILDDIR := obj_dir
RUNARGS  := +verilator+error+limit+1000
LOG      := sim.log
PASSMSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run $(TOP), pass if $(LOG) holds the pass message"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) $(RUNARGS) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== riscvIntCore.f ====
+incdir+source
source/corePkg.sv
source/idExIf.sv
source/registerFile.sv
source/decodeStage.sv
source/alu.sv
source/executeStage.sv
source/riscvIntCore.sv
verif/tbClock.sv
verif/riscvIntCore_assertions.sv
verif/riscvIntCore_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module alu (
    input  corePkg::aluOp         op,
    input  logic [`CORE_XLEN-1:0] operandA,
    input  logic [`CORE_XLEN-1:0] operandB,
    output logic [`CORE_XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = operandB[4:0]; // Only low bits count for shifts

    always_comb begin
        case (op)
            corePkg::aluAdd: result = operandA + operandB;
            corePkg::aluSub: result = operandA - operandB;
            corePkg::aluXor: result = operandA ^ operandB;
            corePkg::aluOr:  result = operandA | operandB;
            corePkg::aluAnd: result = operandA & operandB;
            corePkg::aluSll: result = operandA << shamt;
            corePkg::aluSrl: result = operandA >> shamt;
            // Arithmetic, sign bit fills in
            corePkg::aluSra: result = $signed(operandA) >>> shamt;
            default:         result = '0;
        endcase
    end

endmodule

// ==== source/corePkg.sv ====
package corePkg;

    // Major opcodes handled by the core
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeFields;

    // Register-immediate format
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeFields;

    typedef union packed {
        rTypeFields r;
        iTypeFields i;
    } instrWord;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSll = 4'b0001,
        aluXor = 4'b0100,
        aluSrl = 4'b0101,
        aluOr  = 4'b0110,
        aluAnd = 4'b0111,
        aluSub = 4'b1000,
        aluSra = 4'b1101
    } aluOp;

endpackage

// ==== source/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath and instruction width
`define CORE_XLEN 32

// Integer register file
`define CORE_REG_COUNT 32
`define CORE_REG_ADDR_W 5

`endif

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module decodeStage (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        instrValid,
    input  corePkg::instrWord           instr,
    input  logic [`CORE_XLEN-1:0]       readData1,
    input  logic [`CORE_XLEN-1:0]       readData2,
    output logic [`CORE_REG_ADDR_W-1:0] readAddr1,
    output logic [`CORE_REG_ADDR_W-1:0] readAddr2,
    idExIf.producer                     idEx
);

    corePkg::instrWord     instrReg;
    logic                  instrValidReg;

    logic                  isOp;
    logic                  isOpImm;
    logic [2:0]            funct3;
    logic                  supported;
    logic                  altSel;
    corePkg::aluOp         op;
    logic [`CORE_XLEN-1:0] imm;

    ///////////////////////////////
    // Instruction register
    ///////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            instrValidReg <= 1'b0;
        end else begin
            instrValidReg <= instrValid;
        end
    end

    always_ff @(posedge clock) begin
        instrReg <= instr;
    end

    ///////////////////////////////
    // Control and immediate decode
    ///////////////////////////////

    always_comb begin
        isOp    = instrReg.r.opcode == corePkg::OPCODE_OP;
        isOpImm = instrReg.i.opcode == corePkg::OPCODE_OP_IMM;
        funct3  = instrReg.r.funct3;
        // slt and sltu forms are not implemented
        supported = (isOp || isOpImm) && (funct3 != 3'b010) && (funct3 != 3'b011);
        // Bit 30 picks sra for both formats, sub only for R-type
        altSel = instrReg.r.funct7[5] && ((funct3 == 3'b101) || (isOp && funct3 == 3'b000));
        op     = corePkg::aluOp'({altSel, funct3});
        imm    = {{(`CORE_XLEN-12){instrReg.i.imm12[11]}}, instrReg.i.imm12};
    end

    assign readAddr1 = instrReg.r.rs1;
    assign readAddr2 = instrReg.r.rs2;

    ///////////////////////////////
    // Decode to execute register
    ///////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid <= instrValidReg && supported && (instrReg.r.rd != '0); // Else bubble
        end
    end

    always_ff @(posedge clock) begin
        idEx.op      <= op;
        idEx.rs1     <= instrReg.r.rs1;
        idEx.rs2     <= instrReg.r.rs2;
        idEx.rd      <= instrReg.r.rd;
        idEx.rs1Data <= readData1;
        idEx.rs2Data <= readData2;
        idEx.imm     <= imm;
        idEx.useImm  <= isOpImm;
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module executeStage (
    input  logic                        clock,
    input  logic                        rst,
    idExIf.consumer                     idEx,
    output logic                        wbValid,
    output logic [`CORE_REG_ADDR_W-1:0] wbRd,
    output logic [`CORE_XLEN-1:0]       wbData
);

    logic [`CORE_XLEN-1:0] src1;
    logic [`CORE_XLEN-1:0] src2;
    logic [`CORE_XLEN-1:0] operandB;
    logic [`CORE_XLEN-1:0] aluResult;

    // Distance-1 bypass from the write-back register
    function automatic logic [`CORE_XLEN-1:0] forwardSel(
        input logic [`CORE_REG_ADDR_W-1:0] rs,
        input logic [`CORE_XLEN-1:0]       regData
    );
        return (wbValid && (wbRd == rs)) ? wbData : regData;
    endfunction

    always_comb begin
        src1 = forwardSel(idEx.rs1, idEx.rs1Data);
        src2 = forwardSel(idEx.rs2, idEx.rs2Data);
    end

    assign operandB = idEx.useImm ? idEx.imm : src2;

    alu aluInst (
        .op       (idEx.op),
        .operandA (src1),
        .operandB (operandB),
        .result   (aluResult)
    );

    ///////////////////////////////
    // Write-back register
    ///////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= idEx.valid;
        end
    end

    always_ff @(posedge clock) begin
        wbRd   <= idEx.rd;
        wbData <= aluResult;
    end

endmodule

// ==== source/idExIf.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

interface idExIf;

    logic                        valid;   // Low for bubbles
    corePkg::aluOp               op;
    logic [`CORE_REG_ADDR_W-1:0] rs1;
    logic [`CORE_REG_ADDR_W-1:0] rs2;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [`CORE_XLEN-1:0]       rs1Data;
    logic [`CORE_XLEN-1:0]       rs2Data;
    logic [`CORE_XLEN-1:0]       imm;     // Already sign extended
    logic                        useImm;

    modport producer (
        output valid, op, rs1, rs2, rd, rs1Data, rs2Data, imm, useImm
    );

    modport consumer (
        input valid, op, rs1, rs2, rd, rs1Data, rs2Data, imm, useImm
    );

endinterface

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module registerFile (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        writeEnable,
    input  logic [`CORE_REG_ADDR_W-1:0] writeAddr,
    input  logic [`CORE_XLEN-1:0]       writeData,
    input  logic [`CORE_REG_ADDR_W-1:0] readAddr1,
    input  logic [`CORE_REG_ADDR_W-1:0] readAddr2,
    output logic [`CORE_XLEN-1:0]       readData1,
    output logic [`CORE_XLEN-1:0]       readData2
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    logic writeLive;

    assign writeLive = writeEnable && (writeAddr != '0); // x0 never written

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write wins over the stored word
    function automatic logic [`CORE_XLEN-1:0] readPort(input logic [`CORE_REG_ADDR_W-1:0] addr);
        return (writeLive && (writeAddr == addr)) ? writeData : regs[addr];
    endfunction

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
    end

endmodule

// ==== source/riscvIntCore.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module riscvIntCore (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        instrValid,
    input  logic [`CORE_XLEN-1:0]       instr,
    output logic                        wbValid,
    output logic [`CORE_REG_ADDR_W-1:0] wbRd,
    output logic [`CORE_XLEN-1:0]       wbData
);

    logic [`CORE_REG_ADDR_W-1:0] readAddr1;
    logic [`CORE_REG_ADDR_W-1:0] readAddr2;
    logic [`CORE_XLEN-1:0]       readData1;
    logic [`CORE_XLEN-1:0]       readData2;

    idExIf idExBus ();

    decodeStage decodeInst (
        .clock      (clock),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .readData1  (readData1),
        .readData2  (readData2),
        .readAddr1  (readAddr1),
        .readAddr2  (readAddr2),
        .idEx       (idExBus.producer)
    );

    executeStage executeInst (
        .clock   (clock),
        .rst     (rst),
        .idEx    (idExBus.consumer),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

    // Write port fed straight from the write-back register
    registerFile regFileInst (
        .clock       (clock),
        .rst         (rst),
        .writeEnable (wbValid),
        .writeAddr   (wbRd),
        .writeData   (wbData),
        .readAddr1   (readAddr1),
        .readAddr2   (readAddr2),
        .readData1   (readData1),
        .readData2   (readData2)
    );

endmodule

// ==== verif/riscvIntCore_assertions.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module riscvIntCore_assertions (
    input logic                        clock,
    input logic                        rst,
    input logic                        instrValid,
    input logic [`CORE_XLEN-1:0]       instr,
    input logic                        wbValid,
    input logic [`CORE_REG_ADDR_W-1:0] wbRd
);

    corePkg::instrWord word;
    logic              capturesResult;
    logic              knownOp;
    int                failCount = 0;

    assign word    = instr;
    assign knownOp = (word.r.opcode == corePkg::OPCODE_OP) ||
                     (word.r.opcode == corePkg::OPCODE_OP_IMM);
    assign capturesResult = instrValid && knownOp && (word.r.rd != '0) &&
                            (word.r.funct3 != 3'b010) && (word.r.funct3 != 3'b011);

    // Quiet in reset and in the first cycle out of it
    quietAfterReset: assert property (@(posedge clock) rst |=> !wbValid ##1 !wbValid)
        else begin
            failCount++;
            $error("wbValid went high during or right after reset");
        end

    // Sampled values lag one edge, so two edges after capture shows up as ##3
    fixedLatency: assert property (@(posedge clock) disable iff (rst)
        capturesResult |-> ##3 wbValid)
        else begin
            failCount++;
            $error("No write-back two edges after a valid capture");
        end

    noStrayResult: assert property (@(posedge clock) disable iff (rst)
        wbValid |-> $past(capturesResult, 3))
        else begin
            failCount++;
            $error("Write-back without a matching captured instruction");
        end

    rdNonZero: assert property (@(posedge clock) disable iff (rst) wbValid |-> wbRd != '0)
        else begin
            failCount++;
            $error("Write-back addressed to x0");
        end

endmodule

// ==== verif/riscvIntCore_tb.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module riscvIntCore_tb;

    localparam int RANDOM_COUNT = 400;
    localparam int DRAIN_LIMIT  = 20;

    logic                        clock;
    logic                        rst;
    logic                        instrValid;
    logic [`CORE_XLEN-1:0]       instr;
    logic                        wbValid;
    logic [`CORE_REG_ADDR_W-1:0] wbRd;
    logic [`CORE_XLEN-1:0]       wbData;

    logic [`CORE_XLEN-1:0]       regModel [`CORE_REG_COUNT];
    logic [`CORE_REG_ADDR_W-1:0] expRd [$];
    logic [`CORE_XLEN-1:0]       expData [$];
    int                          dataErrors;
    int                          timeouts;
    int                          wbCount;

    tbClock clockGen (.clock(clock));

    riscvIntCore riscvIntCore_inst (
        .clock      (clock),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    bind riscvIntCore riscvIntCore_assertions assertionsInst (
        .clock      (clock),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbRd       (wbRd)
    );

    //////////////////////////////
    // Instruction builders
    //////////////////////////////

    function automatic corePkg::instrWord makeR(input logic [6:0] funct7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] funct3,
                                                input logic [4:0] rd);
        corePkg::instrWord w;
        w.r = '{funct7, rs2, rs1, funct3, rd, corePkg::OPCODE_OP};
        return w;
    endfunction

    function automatic corePkg::instrWord makeI(input logic [11:0] imm12, input logic [4:0] rs1,
                                                input logic [2:0] funct3, input logic [4:0] rd);
        corePkg::instrWord w;
        w.i = '{imm12, rs1, funct3, rd, corePkg::OPCODE_OP_IMM};
        return w;
    endfunction

    function automatic logic [4:0] randReg();
        return 5'($urandom_range(0, 7)); // Small set keeps dependencies close
    endfunction

    function automatic corePkg::instrWord randomInstr();
        corePkg::instrWord w;
        logic [2:0]        f3;
        logic              alt;
        int                pick;
        pick = $urandom_range(0, 11);
        f3   = 3'($urandom_range(0, 5));
        if (f3 >= 3'd2) begin
            f3 = f3 + 3'd2; // Skip slt and sltu
        end
        alt = ((f3 == 3'b000) || (f3 == 3'b101)) && ($urandom_range(0, 1) == 1);
        if (pick < 6) begin
            w = makeR({1'b0, alt, 5'b0}, randReg(), randReg(), f3, randReg());
        end else if (pick < 10 && (f3 == 3'b001 || f3 == 3'b101)) begin
            w = makeI({1'b0, alt, 5'b0, 5'($urandom)}, randReg(), f3, randReg());
        end else if (pick < 10) begin
            w = makeI(12'($urandom), randReg(), f3, randReg());
        end else if (pick == 10) begin
            w = makeR(7'h00, randReg(), randReg(), 3'b010 | 3'($urandom_range(0, 1)), randReg());
        end else begin
            w = makeI(12'($urandom), randReg(), f3, randReg());
            w.i.opcode = 7'($urandom);
            if (w.i.opcode == corePkg::OPCODE_OP || w.i.opcode == corePkg::OPCODE_OP_IMM) begin
                w.i.opcode = 7'b0000011; // Unsupported load opcode
            end
        end
        return w;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic writesBack(input corePkg::instrWord w);
        logic knownOp;
        knownOp = (w.r.opcode == corePkg::OPCODE_OP) || (w.r.opcode == corePkg::OPCODE_OP_IMM);
        return knownOp && (w.r.funct3 != 3'b010) && (w.r.funct3 != 3'b011) && (w.r.rd != '0);
    endfunction

    function automatic logic [`CORE_XLEN-1:0] computeExpected(input corePkg::instrWord w);
        logic [`CORE_XLEN-1:0]        a;
        logic [`CORE_XLEN-1:0]        b;
        logic signed [`CORE_XLEN-1:0] aSigned;
        logic [`CORE_XLEN-1:0]        sraVal;
        logic                         immForm;
        immForm = w.i.opcode == corePkg::OPCODE_OP_IMM;
        a       = regModel[w.r.rs1];
        b       = immForm ? {{(`CORE_XLEN-12){w.i.imm12[11]}}, w.i.imm12} : regModel[w.r.rs2];
        aSigned = a;
        sraVal  = aSigned >>> b[4:0];
        case (w.r.funct3)
            3'b000:  return (!immForm && w.r.funct7[5]) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b100:  return a ^ b;
            3'b101:  return w.r.funct7[5] ? sraVal : a >> b[4:0]; // Bit 30
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic issueInstr(input corePkg::instrWord w);
        logic [`CORE_XLEN-1:0] result;
        @(posedge clock);
        #1;
        instrValid = 1'b1;
        instr      = w;
        if (writesBack(w)) begin
            result         = computeExpected(w);
            regModel[w.r.rd] = result;
            expRd.push_back(w.r.rd);
            expData.push_back(result);
        end
    endtask

    task automatic idleCycle();
        @(posedge clock);
        #1;
        instrValid = 1'b0;
        instr      = $urandom; // Garbage must be ignored
    endtask

    task automatic runDirected();
        issueInstr(makeI(12'hffd, 5'd0, 3'b000, 5'd1));     // x1 = -3
        issueInstr(makeR(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));  // Distance 1
        issueInstr(makeR(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));  // sub, distances 1 and 2
        issueInstr(makeR(7'h20, 5'd1, 5'd3, 3'b101, 5'd4));  // sra by 29, x1 at distance 3
        issueInstr(makeI(12'h404, 5'd4, 3'b101, 5'd5));     // srai by 4
        issueInstr(makeR(7'h00, 5'd2, 5'd5, 3'b010, 5'd6));  // slt, dropped
        issueInstr(makeI(12'h7ff, 5'd5, 3'b000, 5'd0));     // rd of x0
    endtask

    task automatic drainPipeline();
        int cycles;
        cycles = 0;
        while (expRd.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (expRd.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d expected write-backs still missing after %0d cycles",
                     expRd.size(), DRAIN_LIMIT);
        end
    endtask

    task automatic finishRun();
        int assertErrors;
        assertErrors = riscvIntCore_inst.assertionsInst.failCount;
        $display("Write-backs %0d, data errors %0d, assertion errors %0d, timeouts %0d",
                 wbCount, dataErrors, assertErrors, timeouts);
        if (dataErrors == 0 && assertErrors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clock) begin
        if (!rst && wbValid) begin
            wbCount++;
            assert (expRd.size() != 0) else begin
                dataErrors++;
                $display("Error at %0d ns: write-back to x%0d with nothing pending", $time, wbRd);
            end
            if (expRd.size() != 0) begin
                assert (wbRd == expRd[0] && wbData == expData[0]) else begin
                    dataErrors++;
                    $display("Error at %0d ns: got x%0d = %h, expected x%0d = %h",
                             $time, wbRd, wbData, expRd[0], expData[0]);
                end
                void'(expRd.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(32'h108405c4));
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        dataErrors = 0;
        timeouts   = 0;
        wbCount    = 0;
        for (int r = 0; r < `CORE_REG_COUNT; r++) begin
            regModel[r] = '0;
        end
        repeat (16) @(posedge clock);
        #1;
        rst = 1'b0;
        repeat (6) idleCycle();
        runDirected();
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            issueInstr(randomInstr());
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) idleCycle();
            end
        end
        idleCycle();
        drainPipeline();
        repeat (6) idleCycle();
        finishRun();
    end

endmodule

// ==== verif/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
    parameter int HALF_PERIOD = 2 // 4 ns period
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

endmodule
